// File: rtl/cpu_pkg.sv
//********************************************************************
// CPU package
// Widths, start address and the shared encodings of the single-cycle
// 16-bit load/store core: opcodes, ALU operations, branch conditions
// and writeback sources
//********************************************************************

`default_nettype none

package cpu_pkg;

  // Data path and byte address width
  localparam int word_w = 16;
  // Sixteen architectural registers
  localparam int reg_addr_w = 4;
  // First instruction fetched after reset
  localparam logic [15:0] reset_pc = 16'h0000;

  // Instruction opcodes, bits 15:12
  typedef enum logic [3:0] {
    add_op    = 4'd0,
    sub_op    = 4'd1,
    xor_op    = 4'd2,
    red_op    = 4'd3,
    sll_op    = 4'd4,
    sra_op    = 4'd5,
    ror_op    = 4'd6,
    paddsb_op = 4'd7,
    lw_op     = 4'd8,
    sw_op     = 4'd9,
    llb_op    = 4'd10,
    lhb_op    = 4'd11,
    b_op      = 4'd12,
    br_op     = 4'd13,
    pcs_op    = 4'd14,
    hlt_op    = 4'd15
  } opcode_e;

  // ALU functions
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_xor,
    alu_sll,
    alu_sra,
    alu_ror,
    alu_llb,
    alu_lhb
  } alu_op_e;

  // Branch conditions, bits 11:9 of B and BR
  typedef enum logic [2:0] {
    cond_ne,
    cond_eq,
    cond_gt,
    cond_lt,
    cond_ge,
    cond_le,
    cond_ov,
    cond_al
  } cond_e;

  // Register writeback source
  typedef enum logic [1:0] {
    wb_alu,
    wb_mem,
    wb_pc
  } wb_sel_e;

endpackage

`default_nettype wire

// File: rtl/reg_file.sv
//********************************************************************
// Register file
// Sixteen 16-bit registers, two combinational reads, one write on
// the clock edge, register 0 fixed at zero
//********************************************************************

`timescale 1ns/10ps
`default_nettype none

module reg_file import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [reg_addr_w-1:0] rs_addr,
  input  logic [reg_addr_w-1:0] rt_addr,
  input  logic [reg_addr_w-1:0] rd_addr,
  input  logic [word_w-1:0]     rd_data,
  input  logic                  we,
  output logic [word_w-1:0]     rs_data,
  output logic [word_w-1:0]     rt_data
);

  logic [word_w-1:0] regs [2**reg_addr_w];

  // Writes to register 0 are dropped
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // No bypass, a read alongside a write sees the old value
  assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
  assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

// File: rtl/decoder.sv
//********************************************************************
// Instruction decoder
// Splits an instruction into register addresses, immediate, ALU
// function, write enables, branch and halt controls
//********************************************************************

`timescale 1ns/10ps
`default_nettype none

module decoder import cpu_pkg::*; (
  input  logic [word_w-1:0]     instr,
  output logic [reg_addr_w-1:0] rs_addr,
  output logic [reg_addr_w-1:0] rt_addr,
  output logic [reg_addr_w-1:0] rd_addr,
  output alu_op_e               alu_op,
  output logic [word_w-1:0]     imm,
  output logic                  use_imm,
  output logic                  reg_we,
  output logic                  mem_we,
  output logic                  flag_we_all,
  output logic                  flag_we_z,
  output logic                  is_branch,
  output logic                  is_branch_reg,
  output logic                  is_halt,
  output wb_sel_e               wb_sel,
  output cond_e                 cond
);

  opcode_e op;

  assign op   = opcode_e'(instr[15:12]);
  // Condition field shared by B and BR
  assign cond = cond_e'(instr[11:9]);

  always_comb begin
    // Defaults: plain R-type fields, nothing written
    rd_addr       = instr[11:8];
    rs_addr       = instr[7:4];
    rt_addr       = instr[3:0];
    alu_op        = alu_add;
    imm           = '0;
    use_imm       = 1'b0;
    reg_we        = 1'b0;
    mem_we        = 1'b0;
    flag_we_all   = 1'b0;
    flag_we_z     = 1'b0;
    is_branch     = 1'b0;
    is_branch_reg = 1'b0;
    is_halt       = 1'b0;
    wb_sel        = wb_alu;
    case (op)
      add_op, sub_op: begin
        alu_op      = (op == add_op) ? alu_add : alu_sub;
        reg_we      = 1'b1;
        flag_we_all = 1'b1;
      end
      xor_op: begin
        alu_op    = alu_xor;
        reg_we    = 1'b1;
        flag_we_z = 1'b1;
      end
      sll_op, sra_op, ror_op: begin
        // Shift amount in bits 3:0
        alu_op    = (op == sll_op) ? alu_sll : (op == sra_op) ? alu_sra : alu_ror;
        imm       = {12'b0, instr[3:0]};
        use_imm   = 1'b1;
        reg_we    = 1'b1;
        flag_we_z = 1'b1;
      end
      lw_op, sw_op: begin
        // Halfword offset, sign extended
        imm     = {{11{instr[3]}}, instr[3:0], 1'b0};
        use_imm = 1'b1;
        if (op == lw_op) begin
          reg_we = 1'b1;
          wb_sel = wb_mem;
        end else begin
          // Store data register lives in the rd field
          rt_addr = instr[11:8];
          mem_we  = 1'b1;
        end
      end
      llb_op, lhb_op: begin
        // Read-modify-write of rd
        rs_addr = instr[11:8];
        alu_op  = (op == llb_op) ? alu_llb : alu_lhb;
        imm     = {8'b0, instr[7:0]};
        use_imm = 1'b1;
        reg_we  = 1'b1;
      end
      b_op:   is_branch = 1'b1;
      br_op:  is_branch_reg = 1'b1;
      pcs_op: begin
        reg_we = 1'b1;
        wb_sel = wb_pc;
      end
      hlt_op: is_halt = 1'b1;
      // RED and PADDSB fall through as no-ops
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/alu.sv
//********************************************************************
// ALU and flag register
// Saturating add and subtract, XOR, shifts, rotate and byte loads;
// holds N, Z and V with per-instruction write enables
//********************************************************************

`timescale 1ns/10ps
`default_nettype none

module alu import cpu_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [word_w-1:0] a,
  input  logic [word_w-1:0] b,
  input  alu_op_e           op,
  input  logic              flag_we_all,
  input  logic              flag_we_z,
  output logic [word_w-1:0] result,
  output logic              flag_n,
  output logic              flag_z,
  output logic              flag_v
);

  localparam logic [word_w-1:0] sat_max = 16'h7FFF;
  localparam logic [word_w-1:0] sat_min = 16'h8000;

  logic [word_w-1:0]   sum;
  logic [word_w-1:0]   diff;
  logic                sum_ovf;
  logic                diff_ovf;
  logic [2*word_w-1:0] rot;
  logic                ovf;

  assign sum  = a + b;
  assign diff = a - b;

  // Same-sign operands, result sign flipped
  assign sum_ovf  = (a[word_w-1] == b[word_w-1]) && (sum[word_w-1] != a[word_w-1]);
  // Opposite-sign operands, result sign differs from a
  assign diff_ovf = (a[word_w-1] != b[word_w-1]) && (diff[word_w-1] != a[word_w-1]);

  // Rotate right through a doubled word
  assign rot = {a, a} >> b[3:0];

  always_comb begin
    ovf = 1'b0;
    case (op)
      alu_add: begin
        ovf    = sum_ovf;
        // Clamp toward the sign of the operands
        result = sum_ovf ? (a[word_w-1] ? sat_min : sat_max) : sum;
      end
      alu_sub: begin
        ovf    = diff_ovf;
        result = diff_ovf ? (a[word_w-1] ? sat_min : sat_max) : diff;
      end
      alu_xor: result = a ^ b;
      alu_sll: result = a << b[3:0];
      alu_sra: result = $signed(a) >>> b[3:0];
      alu_ror: result = rot[word_w-1:0];
      // High byte kept, immediate into low byte
      alu_llb: result = {a[15:8], b[7:0]};
      // Low byte kept, immediate into high byte
      alu_lhb: result = {b[7:0], a[7:0]};
      default: result = sum;
    endcase
  end

  // Flag register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flag_n <= 1'b0;
      flag_z <= 1'b0;
      flag_v <= 1'b0;
    end else if (flag_we_all) begin
      flag_n <= result[word_w-1];
      flag_z <= (result == '0);
      flag_v <= ovf;
    end else if (flag_we_z) begin
      // Logic ops and shifts touch Z only
      flag_z <= (result == '0);
    end
  end

endmodule

`default_nettype wire

// File: rtl/pc_unit.sv
//********************************************************************
// Program counter unit
// Holds pc, evaluates branch conditions against the flags and picks
// the next address; pc freezes on halt
//********************************************************************

`timescale 1ns/10ps
`default_nettype none

module pc_unit import cpu_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              is_branch,
  input  logic              is_branch_reg,
  input  logic              is_halt,
  input  cond_e             cond,
  input  logic [8:0]        offset,
  input  logic [word_w-1:0] target_reg,
  input  logic              flag_n,
  input  logic              flag_z,
  input  logic              flag_v,
  output logic [word_w-1:0] pc,
  output logic [word_w-1:0] pc_plus2
);

  logic              taken;
  logic [word_w-1:0] b_target;
  logic [word_w-1:0] pc_next;

  always_comb begin
    case (cond)
      cond_ne: taken = !flag_z;
      cond_eq: taken = flag_z;
      cond_gt: taken = !flag_z && !flag_n;
      cond_lt: taken = flag_n;
      cond_ge: taken = flag_z || (!flag_z && !flag_n);
      cond_le: taken = flag_n || flag_z;
      cond_ov: taken = flag_v;
      default: taken = 1'b1;
    endcase
  end

  assign pc_plus2 = pc + 16'd2;
  // Word offset relative to the next instruction
  assign b_target = pc_plus2 + {{6{offset[8]}}, offset, 1'b0};

  always_comb begin
    if (is_halt) pc_next = pc;
    else if (is_branch && taken) pc_next = b_target;
    else if (is_branch_reg && taken) pc_next = target_reg;
    else pc_next = pc_plus2;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) pc <= reset_pc;
    else pc <= pc_next;
  end

endmodule

`default_nettype wire

// File: rtl/cpu.sv
//********************************************************************
// CPU top level
// Single-cycle core: PC unit, decoder, register file and ALU wired
// to external instruction and data memory ports
//********************************************************************

`timescale 1ns/10ps
`default_nettype none

module cpu import cpu_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [word_w-1:0] imem_data,
  output logic [word_w-1:0] imem_addr,
  output logic [word_w-1:0] dmem_addr,
  output logic [word_w-1:0] dmem_wdata,
  output logic              dmem_we,
  input  logic [word_w-1:0] dmem_rdata,
  output logic              hlt,
  output logic [word_w-1:0] pc
);

  // Decoder controls
  logic [reg_addr_w-1:0] rs_addr;
  logic [reg_addr_w-1:0] rt_addr;
  logic [reg_addr_w-1:0] rd_addr;
  alu_op_e               alu_op;
  logic [word_w-1:0]     imm;
  logic                  use_imm;
  logic                  reg_we;
  logic                  mem_we;
  logic                  flag_we_all;
  logic                  flag_we_z;
  logic                  is_branch;
  logic                  is_branch_reg;
  logic                  is_halt;
  wb_sel_e               wb_sel;
  cond_e                 cond;

  // Datapath
  logic [word_w-1:0] rs_data;
  logic [word_w-1:0] rt_data;
  logic [word_w-1:0] wb_data;
  logic [word_w-1:0] alu_a;
  logic [word_w-1:0] alu_b;
  logic [word_w-1:0] alu_result;
  logic [word_w-1:0] pc_plus2;
  logic              flag_n;
  logic              flag_z;
  logic              flag_v;
  logic              is_mem;

  decoder u_decoder (
    .instr         (imem_data),
    .rs_addr       (rs_addr),
    .rt_addr       (rt_addr),
    .rd_addr       (rd_addr),
    .alu_op        (alu_op),
    .imm           (imm),
    .use_imm       (use_imm),
    .reg_we        (reg_we),
    .mem_we        (mem_we),
    .flag_we_all   (flag_we_all),
    .flag_we_z     (flag_we_z),
    .is_branch     (is_branch),
    .is_branch_reg (is_branch_reg),
    .is_halt       (is_halt),
    .wb_sel        (wb_sel),
    .cond          (cond)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .rd_addr (rd_addr),
    .rd_data (wb_data),
    .we      (reg_we),
    .rs_data (rs_data),
    .rt_data (rt_data)
  );

  // LW and SW address off an even base
  assign is_mem = mem_we | (wb_sel == wb_mem);
  assign alu_a  = is_mem ? {rs_data[word_w-1:1], 1'b0} : rs_data;
  assign alu_b  = use_imm ? imm : rt_data;

  alu u_alu (
    .clk         (clk),
    .rst_n       (rst_n),
    .a           (alu_a),
    .b           (alu_b),
    .op          (alu_op),
    .flag_we_all (flag_we_all),
    .flag_we_z   (flag_we_z),
    .result      (alu_result),
    .flag_n      (flag_n),
    .flag_z      (flag_z),
    .flag_v      (flag_v)
  );

  // Branch offset straight from bits 8:0, BR target from rs
  pc_unit u_pc_unit (
    .clk           (clk),
    .rst_n         (rst_n),
    .is_branch     (is_branch),
    .is_branch_reg (is_branch_reg),
    .is_halt       (is_halt),
    .cond          (cond),
    .offset        (imem_data[8:0]),
    .target_reg    (rs_data),
    .flag_n        (flag_n),
    .flag_z        (flag_z),
    .flag_v        (flag_v),
    .pc            (pc),
    .pc_plus2      (pc_plus2)
  );

  // Writeback source
  always_comb begin
    case (wb_sel)
      wb_mem:  wb_data = dmem_rdata;
      wb_pc:   wb_data = pc_plus2;
      default: wb_data = alu_result;
    endcase
  end

  assign imem_addr  = pc;
  assign dmem_addr  = alu_result;
  // Store data comes from the rt port
  assign dmem_wdata = rt_data;
  // Memory sits outside, so no store escapes while the core is in reset
  assign dmem_we    = mem_we & rst_n;
  assign hlt        = is_halt;

endmodule

`default_nettype wire

// File: bench/tb_cpu_prog.svh
//**********************************************************************
// CPU test program
// Hand-assembled program for the single-cycle core, the stores it must
// make in order as {address, data}, and the address of its HLT
//**********************************************************************

localparam int prog_len = 115;

localparam logic [15:0] prog [prog_len] = '{
  // Bases: r11 = 0100, r12 = 0080, r13 = 0111 (bit 0 dropped by LW and SW)
  16'hBB01, 16'hAC80, 16'hAD11, 16'hBD01,
  // Constants 1234, 7FFF, 8000, ABCD built by LLB and LHB, then stored
  16'hA134, 16'hB112, 16'h91B0, 16'hA2FF, 16'hB27F, 16'h92B1,
  16'hB380, 16'h93B2, 16'hA401, 16'hB6AB, 16'hA6CD, 16'h96B3,
  // 7FFF + 1 and 8000 - 1 clamp, 1234 + ABCD and 1234 - 1 are exact
  16'h0724, 16'h97B4, 16'h1834, 16'h98B5, 16'h0916, 16'h99B6, 16'h1A14, 16'h9AB7,
  // XOR, SLL 4, SRA 4 and ROR 4
  16'h2716, 16'h97D0, 16'h4814, 16'h98D1, 16'h5964, 16'h99D2, 16'h6A14, 16'h9AD3,
  // Load 0100 back twice, second time with offset -16
  16'h87B0, 16'h0874, 16'h98D4, 16'h89D8, 16'h0A99, 16'h9AD5,
  // Z set: ne eq gt lt ge le ov al
  // Each test: LLB taken marker, B cond +1, LLB other marker, SW to 0080
  16'h1711,
  16'hA5A0, 16'hC001, 16'hA550, 16'h95C0,
  16'hA5A1, 16'hC201, 16'hA551, 16'h95C0,
  16'hA5A2, 16'hC401, 16'hA552, 16'h95C0,
  16'hA5A3, 16'hC601, 16'hA553, 16'h95C0,
  16'hA5A4, 16'hC801, 16'hA554, 16'h95C0,
  16'hA5A5, 16'hCA01, 16'hA555, 16'h95C0,
  16'hA5A6, 16'hCC01, 16'hA556, 16'h95C0,
  16'hA5A7, 16'hCE01, 16'hA557, 16'h95C0,
  // N and V set by 8000 - 1: ne eq lt ge ov
  16'h1834,
  16'hA5A8, 16'hC001, 16'hA558, 16'h95C0,
  16'hA5A9, 16'hC201, 16'hA559, 16'h95C0,
  16'hA5AA, 16'hC601, 16'hA55A, 16'h95C0,
  16'hA5AB, 16'hC801, 16'hA55B, 16'h95C0,
  16'hA5AC, 16'hCC01, 16'hA55C, 16'h95C0,
  // All flags clear: gt le al
  16'h0914,
  16'hA5AD, 16'hC401, 16'hA55D, 16'h95C0,
  16'hA5AE, 16'hCA01, 16'hA55E, 16'h95C0,
  16'hA5AF, 16'hCE01, 16'hA55F, 16'h95C0,
  // BR eq falls through to PCS at 00D6, BR al skips to PCS at 00DE
  16'hAFDE, 16'hD2F0, 16'hEE00, 16'h9EC1, 16'hDEF0, 16'h95C2, 16'hEE00, 16'h9EC2,
  // HLT at 00E2, then a store that never runs
  16'hF000, 16'h91B0
};

localparam int store_cnt = 32;

localparam logic [31:0] exp_stores [store_cnt] = '{
  32'h0100_1234, 32'h0102_7FFF, 32'h0104_8000, 32'h0106_ABCD,
  32'h0108_7FFF, 32'h010A_8000, 32'h010C_BE01, 32'h010E_1233,
  32'h0110_B9F9, 32'h0112_2340, 32'h0114_FABC, 32'h0116_4123,
  32'h0118_1235, 32'h011A_2468,
  // Branch markers, A0 plus test number when taken, 50 plus it when not
  32'h0080_0050, 32'h0080_00A1, 32'h0080_0052, 32'h0080_0053,
  32'h0080_00A4, 32'h0080_00A5, 32'h0080_0056, 32'h0080_00A7,
  32'h0080_00A8, 32'h0080_0059, 32'h0080_00AA, 32'h0080_005B,
  32'h0080_00AC, 32'h0080_00AD, 32'h0080_005E, 32'h0080_00AF,
  // PCS results, each instruction's address plus 2
  32'h0082_00D8, 32'h0084_00E0
};

localparam logic [15:0] halt_pc = 16'h00E2;

// File: bench/tb_cpu.sv
//**********************************************************************
// CPU testbench
// Runs a hand-assembled program out of a model instruction memory,
// checks every store in order against a table, then the halt state
//**********************************************************************

`timescale 1ns/10ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

  `include "tb_cpu_prog.svh"

  // Generous bound, most instructions take one cycle
  localparam int timeout_cycles = prog_len * 4;

  logic              clk;
  logic              rst_n;
  logic [word_w-1:0] imem_data;
  logic [word_w-1:0] imem_addr;
  logic [word_w-1:0] dmem_addr;
  logic [word_w-1:0] dmem_wdata;
  logic              dmem_we;
  logic [word_w-1:0] dmem_rdata;
  logic              hlt;
  logic [word_w-1:0] pc;

  // Word memories, indexed by byte address bits 8:1
  logic [word_w-1:0] imem [256];
  logic [word_w-1:0] dmem [256];

  int store_idx;
  int cycles;

  cpu u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_data  (imem_data),
    .imem_addr  (imem_addr),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata),
    .hlt        (hlt),
    .pc         (pc)
  );

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [word_w-1:0] got,
                            input logic [word_w-1:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Fetch on the falling edge, pc is settled by then
  always @(negedge clk) begin
    imem_data <= imem[imem_addr[8:1]];
  end

  // Data memory, combinational read and write on the edge
  assign dmem_rdata = dmem[dmem_addr[8:1]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[8:1]] <= dmem_wdata;
    end
  end

  // Every store is compared with the next table entry
  always @(posedge clk) begin
    if (dmem_we) begin
      if (store_idx >= store_cnt) begin
        stop_with_error($sformatf("Unexpected extra store of %h to address %h",
                                  dmem_wdata, dmem_addr));
      end else begin
        check_word("dmem_addr", dmem_addr, exp_stores[store_idx][31:16]);
        check_word("dmem_wdata", dmem_wdata, exp_stores[store_idx][15:0]);
        store_idx <= store_idx + 1;
      end
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      stop_with_error($sformatf("Timeout, the program did not halt within %0d cycles",
                                timeout_cycles));
    end
  end

  initial begin
    rst_n     = 1'b0;
    imem_data = '0;
    store_idx = 0;
    cycles    = 0;
    // Unused words are HLT with the word index in the low byte
    for (int i = 0; i < 256; i++) begin
      imem[i] = {8'hF0, i[7:0]};
      dmem[i] = {~i[7:0], i[7:0]};
    end
    for (int i = 0; i < prog_len; i++) begin
      imem[i] = prog[i];
    end
    // Four rising edges in reset
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    // Run until HLT is fetched
    while (hlt !== 1'b1) begin
      @(posedge clk);
    end
    check_word("pc", pc, halt_pc);
    check_word("imem_addr", imem_addr, halt_pc);
    // Core stays frozen on the HLT
    repeat (3) begin
      @(posedge clk);
      check_bit("hlt", hlt, 1'b1);
      check_word("pc", pc, halt_pc);
      check_word("imem_addr", imem_addr, halt_pc);
      check_bit("dmem_we", dmem_we, 1'b0);
    end
    if (store_idx != store_cnt) begin
      stop_with_error($sformatf("Only %0d of %0d expected stores were seen",
                                store_idx, store_cnt));
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: cpu.f
+incdir+bench
rtl/cpu_pkg.sv
rtl/reg_file.sv
rtl/decoder.sv
rtl/alu.sv
rtl/pc_unit.sv
rtl/cpu.sv
bench/tb_cpu.sv

// File: Makefile
# Verilator build and run of the CPU testbench

VERILATOR ?= verilator
FILELIST  ?= cpu.f
TB_TOP    ?= tb_cpu
LINT_TOP  ?= cpu
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# Pass only when the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR)
